/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int data_w = 32;
    localparam int addr_w = 12;
    localparam int reg_count = 16;
    localparam int reg_addr_w = $clog2(reg_count);
    localparam int shift_w = $clog2(data_w);
    localparam int mem_words = 1 << addr_w;

    typedef enum logic [3:0] {
        op_nop = 4'b0000,
        op_ld  = 4'b0001,
        op_str = 4'b0010,
        op_bra = 4'b0011,
        op_xor = 4'b0100,
        op_add = 4'b0101,
        op_rot = 4'b0110,
        op_shf = 4'b0111,
        op_hlt = 4'b1000,
        op_cmp = 4'b1001
    } opcode_t; // 1010..1111 run as nop

    typedef enum logic [3:0] {
        c_always   = 4'd0,
        c_parity   = 4'd1,
        c_even     = 4'd2,
        c_carry    = 4'd3,
        c_negative = 4'd4,
        c_zero     = 4'd5,
        c_nocarry  = 4'd6,
        c_positive = 4'd7
    } cond_t; // 8..15 never branch

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback
    } stage_t;

    typedef struct packed {
        opcode_t           opcode;
        logic [3:0]        mode; // condition for bra
        logic [addr_w-1:0] imm;  // low bits also source reg
        logic [addr_w-1:0] dst;  // dest reg, str address, branch target
    } instr_t;

    typedef struct packed {
        logic zero;
        logic negative;
        logic even;
        logic parity;
        logic carry;
    } flags_t;

    typedef struct packed {
        logic              en;
        logic              write;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic              en;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } mem_load_t;

endpackage

`default_nettype wire

/* design/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  cpu_pkg::opcode_t            op,
    input  logic [cpu_pkg::data_w-1:0]  a,
    input  logic [cpu_pkg::data_w-1:0]  b,
    output logic [cpu_pkg::data_w-1:0]  result,
    output logic                        carry
);

    logic [cpu_pkg::data_w:0]       sum;
    logic [2*cpu_pkg::data_w-1:0]   rot_wide;
    logic [cpu_pkg::shift_w-1:0]    shamt;

    assign shamt = b[cpu_pkg::shift_w-1:0];
    assign sum = {1'b0, a} + {1'b0, b};
    assign rot_wide = {a, a} << shamt; // upper half is the rotated word

    always_comb
    begin
        carry = 1'b0;
        case (op)
            cpu_pkg::op_xor: result = a ^ b;
            cpu_pkg::op_add:
            begin
                result = sum[cpu_pkg::data_w-1:0];
                carry = sum[cpu_pkg::data_w];
            end
            cpu_pkg::op_rot: result = rot_wide[2*cpu_pkg::data_w-1 -: cpu_pkg::data_w];
            cpu_pkg::op_shf: result = a << shamt;
            cpu_pkg::op_cmp: result = -a; // two's complement
            default:         result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/psr.sv */
`timescale 1ns/10ps
`default_nettype none

module psr (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        load,
    input  logic [cpu_pkg::data_w-1:0]  result,
    input  logic                        carry,
    output cpu_pkg::flags_t             flags
);

    cpu_pkg::flags_t next_flags;

    always_comb
    begin
        next_flags.zero = (result == '0);
        next_flags.negative = result[cpu_pkg::data_w-1];
        next_flags.even = ~result[0];
        next_flags.parity = ^result; // set on odd parity
        next_flags.carry = carry;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            flags <= '0;
        else if (load)
            flags <= next_flags;
    end

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic                            clk,
    input  logic [cpu_pkg::reg_addr_w-1:0]  rd_addr_a,
    input  logic [cpu_pkg::reg_addr_w-1:0]  rd_addr_b,
    output logic [cpu_pkg::data_w-1:0]      rd_data_a,
    output logic [cpu_pkg::data_w-1:0]      rd_data_b,
    input  logic                            wr_en,
    input  logic [cpu_pkg::reg_addr_w-1:0]  wr_addr,
    input  logic [cpu_pkg::data_w-1:0]      wr_data
);

    logic [cpu_pkg::data_w-1:0] regs [cpu_pkg::reg_count];

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            regs[wr_addr] <= wr_data;
    end

    a_wr_addr_known: assert property (@(posedge clk) wr_en |-> !$isunknown(wr_addr));

endmodule

`default_nettype wire

/* design/cpu_control.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_control (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            run,
    input  logic [cpu_pkg::data_w-1:0]      rdata,
    input  cpu_pkg::flags_t                 flags,
    input  logic [cpu_pkg::data_w-1:0]      rd_data_a,
    input  logic [cpu_pkg::data_w-1:0]      rd_data_b,
    input  logic [cpu_pkg::data_w-1:0]      alu_result,
    input  logic                            alu_carry,
    output cpu_pkg::mem_req_t               mem_req,
    output logic [cpu_pkg::reg_addr_w-1:0]  rd_addr_a,
    output logic [cpu_pkg::reg_addr_w-1:0]  rd_addr_b,
    output logic                            wr_en,
    output logic [cpu_pkg::reg_addr_w-1:0]  wr_addr,
    output logic [cpu_pkg::data_w-1:0]      wr_data,
    output cpu_pkg::opcode_t                alu_op,
    output logic [cpu_pkg::data_w-1:0]      operand1,
    output logic [cpu_pkg::data_w-1:0]      operand2,
    output logic                            flags_load,
    output logic [cpu_pkg::data_w-1:0]      flag_result,
    output logic                            flag_carry,
    output logic                            halted
);

    cpu_pkg::stage_t                stage;
    cpu_pkg::instr_t                ir;
    logic [cpu_pkg::addr_w-1:0]     pc;
    logic [cpu_pkg::addr_w-1:0]     next_pc;
    logic [cpu_pkg::addr_w-1:0]     addr_q;
    logic [cpu_pkg::data_w-1:0]     op1_q;
    logic [cpu_pkg::data_w-1:0]     op2_q;
    logic [cpu_pkg::data_w-1:0]     result_q;
    logic                           take_q;
    logic                           active;
    logic                           alu_instr;
    logic                           store_now;
    logic                           cond_true;

    assign active = run && !halted;
    assign alu_instr = ir.opcode inside {cpu_pkg::op_xor, cpu_pkg::op_add, cpu_pkg::op_rot,
                                         cpu_pkg::op_shf, cpu_pkg::op_cmp};

    always_comb
    begin
        case (cpu_pkg::cond_t'(ir.mode))
            cpu_pkg::c_always:   cond_true = 1'b1;
            cpu_pkg::c_parity:   cond_true = flags.parity;
            cpu_pkg::c_even:     cond_true = flags.even;
            cpu_pkg::c_carry:    cond_true = flags.carry;
            cpu_pkg::c_negative: cond_true = flags.negative;
            cpu_pkg::c_zero:     cond_true = flags.zero;
            cpu_pkg::c_nocarry:  cond_true = !flags.carry;
            cpu_pkg::c_positive: cond_true = !flags.negative && !flags.zero;
            default:             cond_true = 1'b0;
        endcase
    end

    assign next_pc = take_q ? ir.dst : pc + 1'b1;

    // register file and alu hookup
    assign rd_addr_a = ir.imm[cpu_pkg::reg_addr_w-1:0];
    assign rd_addr_b = ir.dst[cpu_pkg::reg_addr_w-1:0];
    assign alu_op = ir.opcode;
    assign operand1 = op1_q;
    assign operand2 = op2_q;
    assign flags_load = active && (stage == cpu_pkg::st_execute) && alu_instr;
    assign flag_result = alu_result;
    assign flag_carry = alu_carry;

    assign wr_en = active && (stage == cpu_pkg::st_writeback)
                   && (alu_instr || ir.opcode == cpu_pkg::op_ld);
    assign wr_addr = ir.dst[cpu_pkg::reg_addr_w-1:0];
    assign wr_data = (ir.opcode == cpu_pkg::op_ld) ? rdata : result_q;

    // str writes straight from the execute stage
    assign store_now = active && (stage == cpu_pkg::st_execute)
                       && (ir.opcode == cpu_pkg::op_str);
    assign mem_req.en = store_now;
    assign mem_req.write = store_now;
    assign mem_req.addr = store_now ? ir.dst : addr_q;
    assign mem_req.wdata = op1_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stage <= cpu_pkg::st_fetch;
            pc <= '0;
            addr_q <= '0;
            take_q <= 1'b0;
            halted <= 1'b0;
        end
        else if (active)
        begin
            case (stage)
                cpu_pkg::st_fetch: stage <= cpu_pkg::st_decode;
                cpu_pkg::st_decode: stage <= cpu_pkg::st_execute;
                cpu_pkg::st_execute:
                begin
                    stage <= cpu_pkg::st_memory;
                    take_q <= (ir.opcode == cpu_pkg::op_bra) && cond_true;
                    if (ir.opcode == cpu_pkg::op_ld)
                        addr_q <= ir.imm; // load address
                    if (ir.opcode == cpu_pkg::op_hlt)
                        halted <= 1'b1;
                end
                cpu_pkg::st_memory:
                begin
                    stage <= cpu_pkg::st_writeback;
                    pc <= next_pc;
                    addr_q <= next_pc; // ready for the next fetch
                end
                default: stage <= cpu_pkg::st_fetch;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (active)
        begin
            case (stage)
                cpu_pkg::st_fetch: ir <= cpu_pkg::instr_t'(rdata);
                cpu_pkg::st_decode:
                begin
                    op1_q <= ir.mode[3] ? cpu_pkg::data_w'(ir.imm) : rd_data_a;
                    op2_q <= ir.mode[2] ? '0 : rd_data_b;
                end
                cpu_pkg::st_execute: result_q <= alu_result;
                default: ;
            endcase
        end
    end

    a_store_in_execute: assert property (@(posedge clk) disable iff (reset)
        (mem_req.en && mem_req.write) |=> stage == cpu_pkg::st_memory && !mem_req.write);

    a_stage_legal: assert property (@(posedge clk) disable iff (reset)
        stage inside {cpu_pkg::st_fetch, cpu_pkg::st_decode, cpu_pkg::st_execute,
                      cpu_pkg::st_memory, cpu_pkg::st_writeback});

endmodule

`default_nettype wire

/* design/data_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module data_mem (
    input  logic                        clk,
    input  cpu_pkg::mem_req_t           cpu_req,
    output logic [cpu_pkg::data_w-1:0]  rdata,
    input  cpu_pkg::mem_load_t          load,
    input  logic [cpu_pkg::addr_w-1:0]  peek_addr,
    output logic [cpu_pkg::data_w-1:0]  peek_data
);

    logic [cpu_pkg::data_w-1:0] mem [cpu_pkg::mem_words];

    always_ff @(posedge clk)
    begin
        if (load.en)
            mem[load.addr] <= load.data; // load port wins
        else if (cpu_req.en && cpu_req.write)
            mem[cpu_req.addr] <= cpu_req.wdata;
        rdata <= mem[cpu_req.addr];
        peek_data <= mem[peek_addr];
    end

endmodule

`default_nettype wire

/* design/cpu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        run,
    input  cpu_pkg::mem_load_t          load,
    input  logic [cpu_pkg::addr_w-1:0]  peek_addr,
    output logic [cpu_pkg::data_w-1:0]  peek_data,
    output logic                        halted
);

    cpu_pkg::mem_req_t              mem_req;
    cpu_pkg::flags_t                flags;
    cpu_pkg::opcode_t               alu_op;
    logic [cpu_pkg::data_w-1:0]     rdata;
    logic [cpu_pkg::reg_addr_w-1:0] rd_addr_a;
    logic [cpu_pkg::reg_addr_w-1:0] rd_addr_b;
    logic [cpu_pkg::data_w-1:0]     rd_data_a;
    logic [cpu_pkg::data_w-1:0]     rd_data_b;
    logic                           wr_en;
    logic [cpu_pkg::reg_addr_w-1:0] wr_addr;
    logic [cpu_pkg::data_w-1:0]     wr_data;
    logic [cpu_pkg::data_w-1:0]     operand1;
    logic [cpu_pkg::data_w-1:0]     operand2;
    logic [cpu_pkg::data_w-1:0]     alu_result;
    logic                           alu_carry;
    logic                           flags_load;
    logic [cpu_pkg::data_w-1:0]     flag_result;
    logic                           flag_carry;

    cpu_control u_control (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .rdata       (rdata),
        .flags       (flags),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .alu_result  (alu_result),
        .alu_carry   (alu_carry),
        .mem_req     (mem_req),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .alu_op      (alu_op),
        .operand1    (operand1),
        .operand2    (operand2),
        .flags_load  (flags_load),
        .flag_result (flag_result),
        .flag_carry  (flag_carry),
        .halted      (halted)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    alu u_alu (
        .op     (alu_op),
        .a      (operand1),
        .b      (operand2),
        .result (alu_result),
        .carry  (alu_carry)
    );

    psr u_psr (
        .clk    (clk),
        .reset  (reset),
        .load   (flags_load),
        .result (flag_result),
        .carry  (flag_carry),
        .flags  (flags)
    );

    data_mem u_mem (
        .clk       (clk),
        .cpu_req   (mem_req),
        .rdata     (rdata),
        .load      (load),
        .peek_addr (peek_addr),
        .peek_data (peek_data)
    );

endmodule

`default_nettype wire

/* include/cpu_tb_programs.svh */
`ifndef CPU_TB_PROGRAMS_SVH
`define CPU_TB_PROGRAMS_SVH

localparam int tb_image_words = 24;
localparam int tb_check_count = 4;
localparam int tb_prog_count = 5;

typedef struct packed {
    logic [8*12-1:0]                                name;
    logic [0:tb_image_words-1][cpu_pkg::data_w-1:0] image;    // word i sits at address i
    logic [15:0]                                    count;    // executed instructions, hlt too
    logic [0:tb_check_count-1][cpu_pkg::addr_w-1:0] chk_addr;
    logic [0:tb_check_count-1][cpu_pkg::data_w-1:0] chk_word;
} tb_prog_t;

localparam tb_prog_t tb_progs [tb_prog_count] = '{
    '{"ld_add_str",
      {32'h10010001, 32'h10011002, 32'h50001002, 32'h20002014, 32'h10012003, 32'h50003003,
       32'h33000009, 32'h280BA015, 32'h80000000, 32'h280C1015, 32'h20003016, 32'h80000000,
       {4{32'h0}}, 32'h12345678, 32'h11111111, 32'h80000001, {5{32'h0}}},
      16'd10, {12'd20, 12'd21, 12'd22, 12'd16},
      {32'h23456789, 32'h000000C1, 32'h00000002, 32'h12345678}},
    '{"alu_ops",
      {32'h10014001, 32'h480FF001, 32'h20001010, 32'h10015002, 32'h60001002, 32'h20002011,
       32'h78123002, 32'h20002012, 32'h94002003, 32'h20003013, 32'h80000000,
       {9{32'h0}}, 32'h800000F1, 32'h00000004, {2{32'h0}}},
      16'd11, {12'd16, 12'd17, 12'd18, 12'd19},
      {32'h8000000E, 32'h000000E8, 32'h00012300, 32'hFFFEDD00}},
    '{"branch_taken",
      {32'h4C001000, 32'h31000003, 32'h280A1017, 32'h37000005, 32'h280A7017, 32'h36000007,
       32'h280A6017, 32'h4C000000, 32'h3500000A, 32'h280A5017, 32'h3200000C, 32'h280A2017,
       32'h9C001001, 32'h3400000F, 32'h280A4017, 32'h50001001, 32'h33000012, 32'h280A3017,
       32'h30000014, 32'h280A0017, 32'h280DD016, 32'h80000000, {2{32'h0}}},
      16'd14, {12'd22, 12'd23, 12'd21, 12'd19},
      {32'h000000DD, 32'h00000000, 32'h80000000, 32'h280A0017}},
    '{"branch_fall",
      {32'h4C000000, 32'h31000016, 32'h34000016, 32'h37000016, 32'h33000016, 32'h4C001000,
       32'h35000016, 32'h32000016, 32'h9C001001, 32'h50001001, 32'h36000016, 32'h38000016,
       32'h280DD015, 32'h80000000, {8{32'h0}}, 32'h280BB015, 32'h80000000},
      16'd14, {12'd21, 12'd22, 12'd23, 12'd0},
      {32'h000000DD, 32'h280BB015, 32'h80000000, 32'h4C000000}},
    '{"loop_halt",
      {32'h4C000001, 32'h10014003, 32'h58001001, 32'h58001003, 32'h34000002, 32'h20001015,
       32'h80000000, 32'h280EE016, {12{32'h0}}, 32'hFFFFFFFB, {3{32'h0}}},
      16'd19, {12'd21, 12'd22, 12'd20, 12'd7},
      {32'h00000005, 32'h00000000, 32'hFFFFFFFB, 32'h280EE016}}
};

`endif

/* tests/cpu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_tb;

    `include "cpu_tb_programs.svh"

    localparam int clk_period = 100;
    localparam int drive_delay = 10;
    localparam int pause_cycles = 7;
    localparam int pause_at = 12; // edge after which run drops in the paused rerun

    logic                          clk;
    logic                          reset;
    logic                          run;
    cpu_pkg::mem_load_t            load;
    logic [cpu_pkg::addr_w-1:0]    peek_addr;
    logic [cpu_pkg::data_w-1:0]    peek_data;
    logic                          halted;

    cpu_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .load      (load),
        .peek_addr (peek_addr),
        .peek_data (peek_data),
        .halted    (halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // each program gets 5 cycles per instruction plus setup and peek time
    function automatic longint watchdog_cycles();
        longint total;
        total = 0;
        for (int p = 0; p < tb_prog_count; p++)
            total += 5 * tb_progs[p].count + 50;
        total += 5 * tb_progs[tb_prog_count-1].count + pause_cycles + 50; // paused rerun
        return total;
    endfunction

    initial
    begin
        #(watchdog_cycles() * clk_period);
        $display("watchdog expired: halted never rose");
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    task automatic wait_drive_point();
        @(posedge clk);
        #(drive_delay);
    endtask

    task automatic check_word(input logic [8*12-1:0] test_name, input string what,
                              input logic [cpu_pkg::data_w-1:0] expected,
                              input logic [cpu_pkg::data_w-1:0] actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %0s %0s: expected %h, actual %h",
                     test_name, what, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_count(input logic [8*12-1:0] test_name, input string what,
                               input int expected, input int actual);
        if (actual != expected)
        begin
            $display("CHECK FAILED %0s %0s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic check_halt_holds(input logic [8*12-1:0] test_name, input int cycles);
        for (int c = 0; c < cycles; c++)
        begin
            wait_drive_point();
            if (!halted)
            begin
                $display("%0s: halted fell again while run was still high", test_name);
                $display("Simulation FAILED");
                $fatal(1, "halted fell");
            end
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        run = 1'b0;
        repeat (4) wait_drive_point();
        reset = 1'b0;
    endtask

    task automatic load_image(input int p);
        for (int i = 0; i < tb_image_words; i++)
        begin
            load.en = 1'b1;
            load.addr = cpu_pkg::addr_w'(i);
            load.data = tb_progs[p].image[i];
            wait_drive_point();
        end
        load = '0;
    endtask

    // counts edges from the first one with run high up to the one that sets halted
    task automatic run_until_halt(input int pause_edge, output int edges);
        int low_left;
        edges = 0;
        low_left = 0;
        run = 1'b1;
        do
        begin
            wait_drive_point();
            edges++;
            if (low_left > 0)
            begin
                low_left--;
                if (low_left == 0)
                    run = 1'b1;
            end
            else if (edges == pause_edge && !halted)
            begin
                run = 1'b0; // hold the sequencer mid-program
                low_left = pause_cycles;
            end
        end
        while (!halted);
    endtask

    task automatic run_program(input int p, input int pause_edge);
        int edges;
        int expected;
        apply_reset();
        load_image(p);
        wait_drive_point();
        run_until_halt(pause_edge, edges);
        expected = 5 * (int'(tb_progs[p].count) - 1) + 3;
        if (pause_edge > 0)
            expected += pause_cycles;
        check_count(tb_progs[p].name, (pause_edge > 0) ? "cycles with pause" : "cycles",
                    expected, edges);
        check_halt_holds(tb_progs[p].name, 5);
        run = 1'b0;
        for (int k = 0; k < tb_check_count; k++)
        begin
            peek_addr = tb_progs[p].chk_addr[k];
            wait_drive_point();
            check_word(tb_progs[p].name, $sformatf("mem[%0d]", tb_progs[p].chk_addr[k]),
                       tb_progs[p].chk_word[k], peek_data);
        end
    endtask

    initial
    begin
        reset = 1'b1;
        run = 1'b0;
        load = '0;
        peek_addr = '0;
        for (int p = 0; p < tb_prog_count; p++)
            run_program(p, 0);
        run_program(tb_prog_count - 1, pause_at); // same words expected after a pause
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
design/cpu_pkg.sv
design/alu.sv
design/psr.sv
design/reg_file.sv
design/cpu_control.sv
design/data_mem.sv
design/cpu_top.sv
tests/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f all.f

out=$(./obj_dir/Vcpu_tb) || true
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
    exit 0
else
    exit 1
fi
